// File: pr_queue_pkg.sv
package pr_queue_pkg;

    // ####################
    // Request fields
    // ####################

    localparam int GRID_SLOT_W = 6;                    // 64 grid slots
    localparam int OU_ID_W = 3;
    localparam int PR_REQUEST_W = OU_ID_W + GRID_SLOT_W;

    typedef logic [GRID_SLOT_W-1:0] grid_slot_t;
    typedef logic [OU_ID_W-1:0] ou_id_t;

    // OU id on top, grid slot below, same order as the bus word
    typedef logic [PR_REQUEST_W-1:0] pr_request_t;

    // ####################
    // Bus types
    // ####################

    typedef logic [1:0] axi_addr_t;                    // Word index
    typedef logic [31:0] axi_data_t;

    // ####################
    // Register map
    // ####################

    localparam axi_addr_t ENQUEUE_ADDR = 2'd1;         // Write side
    localparam axi_addr_t PEEK_ADDR = 2'd1;            // Read side, head stays
    localparam axi_addr_t POP_ADDR = 2'd2;             // Read side, head removed

    localparam int DEFAULT_QUEUE_DEPTH = 8;

endpackage

// File: pr_fifo_if.sv
`timescale 1ns/100ps

interface pr_fifo_if;
    import pr_queue_pkg::*;

    logic push;
    pr_request_t push_data;
    logic credit_return;                               // One pulse per removed entry
    logic head_valid;
    pr_request_t head_data;
    logic pop;

    modport writer (
        output push,
        output push_data,
        input  credit_return
    );

    modport queue (
        input  push,
        input  push_data,
        input  pop,
        output credit_return,
        output head_valid,
        output head_data
    );

    modport reader (
        input  head_valid,
        input  head_data,
        output pop
    );

endinterface

// File: pr_write_decode.sv
`timescale 1ns/100ps

module pr_write_decode #(
    parameter int QUEUE_DEPTH = pr_queue_pkg::DEFAULT_QUEUE_DEPTH
) (
    input  logic                    s_axi_aclk,
    input  logic                    s_axi_aresetn,
    input  pr_queue_pkg::axi_addr_t awaddr,
    input  logic                    awvalid,
    output logic                    awready,
    input  pr_queue_pkg::axi_data_t wdata,
    input  logic                    wvalid,
    output logic                    wready,
    output logic                    bvalid,
    input  logic                    bready,
    pr_fifo_if.writer               fifo
);
    import pr_queue_pkg::*;

    localparam int CREDIT_W = $clog2(QUEUE_DEPTH + 1);

    typedef enum logic [1:0] {
        W_ADDR,
        W_DATA,
        W_RESP
    } wstate_t;

    wstate_t wstate;
    logic [CREDIT_W-1:0] credits;
    logic credit_avail;
    grid_slot_t wr_slot;
    ou_id_t wr_ou;

    assign credit_avail = (credits != '0);
    assign wr_slot = wdata[GRID_SLOT_W-1:0];
    assign wr_ou = wdata[GRID_SLOT_W +: OU_ID_W];      // Upper data bits dropped

    // ####################
    // Write channel FSM
    // ####################

    always_ff @(posedge s_axi_aclk) begin
        if (s_axi_aresetn) begin
            wstate <= W_ADDR;
            awready <= 1'b0;
            wready <= 1'b0;
            bvalid <= 1'b0;
            fifo.push <= 1'b0;
        end else begin
            awready <= 1'b0;
            wready <= 1'b0;
            fifo.push <= 1'b0;
            case (wstate)
                W_ADDR: begin
                    // Other addresses are left hanging
                    if (awvalid && (awaddr == ENQUEUE_ADDR) && credit_avail) begin
                        awready <= 1'b1;
                        wstate <= W_DATA;
                    end
                end
                W_DATA: begin
                    if (wvalid) begin
                        wready <= 1'b1;
                        fifo.push <= 1'b1;
                        wstate <= W_RESP;
                    end
                end
                W_RESP: begin
                    if (!bvalid) begin
                        bvalid <= 1'b1;                // Always OKAY
                    end else if (bready) begin
                        bvalid <= 1'b0;
                        wstate <= W_ADDR;
                    end
                end
                default: wstate <= W_ADDR;
            endcase
        end
    end

    always_ff @(posedge s_axi_aclk) begin
        if ((wstate == W_DATA) && wvalid) begin
            fifo.push_data <= {wr_ou, wr_slot};
        end
    end

    // ####################
    // Credit counter
    // ####################

    always_ff @(posedge s_axi_aclk) begin
        if (s_axi_aresetn) begin
            credits <= CREDIT_W'(QUEUE_DEPTH);         // Queue starts empty
        end else begin
            case ({fifo.push, fifo.credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;           // Both or neither
            endcase
        end
    end

    assert property (@(posedge s_axi_aclk) disable iff (s_axi_aresetn)
        credits <= CREDIT_W'(QUEUE_DEPTH))
        else $error("credit count above queue depth");

    assert property (@(posedge s_axi_aclk) disable iff (s_axi_aresetn)
        fifo.push |-> credit_avail)
        else $error("push issued with no credit left");

endmodule

// File: pr_request_fifo.sv
`timescale 1ns/100ps

module pr_request_fifo #(
    parameter int QUEUE_DEPTH = pr_queue_pkg::DEFAULT_QUEUE_DEPTH
) (
    input  logic      s_axi_aclk,
    input  logic      s_axi_aresetn,
    pr_fifo_if.queue  fifo
);
    import pr_queue_pkg::*;

    localparam int PTR_W = $clog2(QUEUE_DEPTH);
    localparam int COUNT_W = $clog2(QUEUE_DEPTH + 1);

    pr_request_t mem [QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [COUNT_W-1:0] count;
    logic do_pop;

    // Wraps for depths that are not a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(QUEUE_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign do_pop = fifo.pop && fifo.head_valid;
    assign fifo.head_valid = (count != '0);
    assign fifo.head_data = mem[rd_ptr];
    assign fifo.credit_return = do_pop;                // Same cycle as the pop

    // ####################
    // Storage
    // ####################

    always_ff @(posedge s_axi_aclk) begin
        if (fifo.push) begin
            mem[wr_ptr] <= fifo.push_data;
        end
    end

    always_ff @(posedge s_axi_aclk) begin
        if (s_axi_aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (fifo.push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({fifo.push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assert property (@(posedge s_axi_aclk) disable iff (s_axi_aresetn)
        fifo.push |-> (count != COUNT_W'(QUEUE_DEPTH)))
        else $error("push into a full request queue");

    assert property (@(posedge s_axi_aclk) disable iff (s_axi_aresetn)
        fifo.pop |-> (count != '0))
        else $error("pop from an empty request queue");

endmodule

// File: pr_read_result.sv
`timescale 1ns/100ps

module pr_read_result (
    input  logic                    s_axi_aclk,
    input  logic                    s_axi_aresetn,
    input  pr_queue_pkg::axi_addr_t araddr,
    input  logic                    arvalid,
    output logic                    arready,
    output pr_queue_pkg::axi_data_t rdata,
    output logic                    rvalid,
    input  logic                    rready,
    pr_fifo_if.reader               fifo
);
    import pr_queue_pkg::*;

    typedef enum logic [1:0] {
        R_ADDR,
        R_CAPTURE,
        R_DATA
    } rstate_t;

    rstate_t rstate;
    logic pop_req;                                     // Set for a pop, clear for a peek

    // ####################
    // Read channel FSM
    // ####################

    always_ff @(posedge s_axi_aclk) begin
        if (s_axi_aresetn) begin
            rstate <= R_ADDR;
            arready <= 1'b0;
            rvalid <= 1'b0;
            pop_req <= 1'b0;
            fifo.pop <= 1'b0;
        end else begin
            arready <= 1'b0;
            fifo.pop <= 1'b0;
            case (rstate)
                R_ADDR: begin
                    // Empty queue leaves the address waiting
                    if (arvalid && fifo.head_valid) begin
                        arready <= 1'b1;
                        pop_req <= (araddr == POP_ADDR);
                        rstate <= R_CAPTURE;
                    end
                end
                R_CAPTURE: begin
                    rvalid <= 1'b1;
                    fifo.pop <= pop_req;
                    rstate <= R_DATA;
                end
                R_DATA: begin
                    if (rready) begin
                        rvalid <= 1'b0;
                        rstate <= R_ADDR;
                    end
                end
                default: rstate <= R_ADDR;
            endcase
        end
    end

    always_ff @(posedge s_axi_aclk) begin
        if (rstate == R_CAPTURE) begin
            rdata <= axi_data_t'(fifo.head_data);      // Zero-extended
        end
    end

    assert property (@(posedge s_axi_aclk) disable iff (s_axi_aresetn)
        (rvalid && !rready) |=> (rvalid && $stable(rdata)))
        else $error("read data changed before the handshake");

endmodule

// File: axi_pr_queue.sv
`timescale 1ns/100ps

module axi_pr_queue #(
    parameter int QUEUE_DEPTH = pr_queue_pkg::DEFAULT_QUEUE_DEPTH
) (
    input  logic                    s_axi_aclk,
    input  logic                    s_axi_aresetn,
    input  pr_queue_pkg::axi_addr_t s_axi_awaddr,
    input  logic                    s_axi_awvalid,
    output logic                    s_axi_awready,
    input  pr_queue_pkg::axi_data_t s_axi_wdata,
    input  logic                    s_axi_wvalid,
    output logic                    s_axi_wready,
    output logic                    s_axi_bvalid,
    input  logic                    s_axi_bready,
    input  pr_queue_pkg::axi_addr_t s_axi_araddr,
    input  logic                    s_axi_arvalid,
    output logic                    s_axi_arready,
    output pr_queue_pkg::axi_data_t s_axi_rdata,
    output logic                    s_axi_rvalid,
    input  logic                    s_axi_rready,
    output logic                    pr_request_pending
);

    pr_fifo_if fifo_if ();

    pr_write_decode #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) u_write_decode (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn),
        .awaddr        (s_axi_awaddr),
        .awvalid       (s_axi_awvalid),
        .awready       (s_axi_awready),
        .wdata         (s_axi_wdata),
        .wvalid        (s_axi_wvalid),
        .wready        (s_axi_wready),
        .bvalid        (s_axi_bvalid),
        .bready        (s_axi_bready),
        .fifo          (fifo_if.writer)
    );

    pr_request_fifo #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) u_request_fifo (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn),
        .fifo          (fifo_if.queue)
    );

    pr_read_result u_read_result (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn),
        .araddr        (s_axi_araddr),
        .arvalid       (s_axi_arvalid),
        .arready       (s_axi_arready),
        .rdata         (s_axi_rdata),
        .rvalid        (s_axi_rvalid),
        .rready        (s_axi_rready),
        .fifo          (fifo_if.reader)
    );

    assign pr_request_pending = fifo_if.head_valid;    // To the reconfiguration controller

endmodule

// File: tb_axi_pr_queue.sv
`timescale 1ns/100ps

module tb_axi_pr_queue;
    import pr_queue_pkg::*;

    typedef enum {OP_ENQ, OP_PEEK, OP_POP, OP_BLOCKED} op_t;

    localparam int STEP_CYCLES = 60;
    localparam int RESET_CYCLES = 16;
    localparam int WAIT_LIMIT = 40;                    // Cycles per handshake
    localparam int BLOCK_CYCLES = 20;

    logic s_axi_aclk;
    logic s_axi_aresetn;
    axi_addr_t s_axi_awaddr;
    logic s_axi_awvalid;
    logic s_axi_awready;
    axi_data_t s_axi_wdata;
    logic s_axi_wvalid;
    logic s_axi_wready;
    logic s_axi_bvalid;
    logic s_axi_bready;
    axi_addr_t s_axi_araddr;
    logic s_axi_arvalid;
    logic s_axi_arready;
    axi_data_t s_axi_rdata;
    logic s_axi_rvalid;
    logic s_axi_rready;
    logic pr_request_pending;

    op_t step_op[$];
    axi_addr_t step_addr[$];
    axi_data_t step_data[$];
    string step_name[$];
    pr_request_t model_q[$];                           // Reference queue
    logic [15:0] lfsr = 16'd18;
    int mismatch_count = 0;
    int failure_count = 0;
    int cycle_count = 0;
    int cycle_limit = 0;

    axi_pr_queue DUT (.*);

    initial begin
        s_axi_aclk = 1'b0;
        forever #20 s_axi_aclk = ~s_axi_aclk;
    end

    always @(posedge s_axi_aclk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
            $display("Run stopped after %0d cycles, a handshake never finished", cycle_count);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // Galois form, taps 16,14,13,11
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
    endfunction

    task automatic take_bits(input int count, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < count; i++) begin
            lfsr = lfsr_next(lfsr);
            bits = {bits[30:0], lfsr[0]};
        end
    endtask

    task automatic add_step(input op_t op, input axi_addr_t addr, input axi_data_t data,
                            input string name);
        step_op.push_back(op);
        step_addr.push_back(addr);
        step_data.push_back(data);
        step_name.push_back(name);
    endtask

    // ####################
    // Compare tasks
    // ####################

    task automatic check_request(input string name, input pr_request_t exp, input axi_data_t act);
        if (act !== axi_data_t'(exp)) begin
            $display("MISMATCH %s: expected %h, actual %h", name, axi_data_t'(exp), act);
            mismatch_count++;
        end
    endtask

    task automatic check_data(input string name, input axi_data_t exp, input axi_data_t act);
        if (act !== exp) begin
            $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
            mismatch_count++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("MISMATCH %s pending: expected %b, actual %b", name, exp, act);
            mismatch_count++;
        end
    endtask

    // ####################
    // Bus tasks
    // ####################

    task automatic do_write(input string name, input axi_addr_t addr, input axi_data_t data,
                            input bit expect_accept);
        int n;
        logic [31:0] stall;
        @(posedge s_axi_aclk);
        s_axi_awaddr <= addr;
        s_axi_awvalid <= 1'b1;
        s_axi_wdata <= data;
        s_axi_wvalid <= 1'b1;
        n = 0;
        do begin
            @(posedge s_axi_aclk);
            n++;
        end while (!s_axi_awready && n < (expect_accept ? WAIT_LIMIT : BLOCK_CYCLES));
        s_axi_awvalid <= 1'b0;
        if (!expect_accept) begin
            s_axi_wvalid <= 1'b0;
            if (s_axi_awready) begin
                $display("%s: write address was accepted but should have waited", name);
                failure_count++;
            end
            return;
        end
        if (!s_axi_awready) begin
            $display("%s: write address was never accepted", name);
            failure_count++;
        end
        n = 0;
        do begin
            @(posedge s_axi_aclk);
            n++;
        end while (!s_axi_wready && n < WAIT_LIMIT);
        s_axi_wvalid <= 1'b0;
        if (!s_axi_wready) begin
            $display("%s: write data was never accepted", name);
            failure_count++;
        end
        n = 0;
        while (!(s_axi_bvalid && s_axi_bready) && n < WAIT_LIMIT) begin
            take_bits(1, stall);
            s_axi_bready <= stall[0];                  // Random back-pressure
            @(posedge s_axi_aclk);
            n++;
        end
        s_axi_bready <= 1'b0;
        if (n >= WAIT_LIMIT) begin
            $display("%s: write response never completed", name);
            failure_count++;
        end
    endtask

    task automatic do_read(input string name, input axi_addr_t addr, input pr_request_t exp);
        int n;
        logic [31:0] stall;
        axi_data_t first;
        bit held;
        held = 1'b0;
        first = '0;
        @(posedge s_axi_aclk);
        s_axi_araddr <= addr;
        s_axi_arvalid <= 1'b1;
        n = 0;
        do begin
            @(posedge s_axi_aclk);
            n++;
        end while (!s_axi_arready && n < WAIT_LIMIT);
        s_axi_arvalid <= 1'b0;
        if (!s_axi_arready) begin
            $display("%s: read address was never accepted", name);
            failure_count++;
        end
        n = 0;
        while (!(s_axi_rvalid && s_axi_rready) && n < WAIT_LIMIT) begin
            if (s_axi_rvalid && !held) begin
                first = s_axi_rdata;
                held = 1'b1;
            end else if (s_axi_rvalid) begin
                check_data({name, "_hold"}, first, s_axi_rdata);
            end
            take_bits(1, stall);
            s_axi_rready <= stall[0];
            @(posedge s_axi_aclk);
            n++;
        end
        s_axi_rready <= 1'b0;
        if (n >= WAIT_LIMIT) begin
            $display("%s: read data never arrived", name);
            failure_count++;
        end
        if (held) begin
            check_data({name, "_hold"}, first, s_axi_rdata);
        end
        check_request(name, exp, s_axi_rdata);
    endtask

    // ####################
    // Step table and run
    // ####################

    initial begin
        logic [31:0] rnd;
        axi_data_t wdata_now;
        pr_request_t exp;
        s_axi_aresetn = 1'b1;
        s_axi_awaddr = '0;
        s_axi_awvalid = 1'b0;
        s_axi_wdata = '0;
        s_axi_wvalid = 1'b0;
        s_axi_bready = 1'b0;
        s_axi_araddr = '0;
        s_axi_arvalid = 1'b0;
        s_axi_rready = 1'b0;

        add_step(OP_ENQ, ENQUEUE_ADDR, 32'h0000_0123, "enq_a");
        add_step(OP_ENQ, ENQUEUE_ADDR, 32'hFFFF_FE5A, "enq_b");
        add_step(OP_PEEK, PEEK_ADDR, '0, "peek_a");
        add_step(OP_PEEK, 2'd3, '0, "peek_a_other_addr");
        add_step(OP_POP, POP_ADDR, '0, "pop_a");
        add_step(OP_POP, POP_ADDR, '0, "pop_b");
        for (int i = 0; i < DEFAULT_QUEUE_DEPTH; i++) begin
            add_step(OP_ENQ, ENQUEUE_ADDR, 32'h40 + 32'(i * 37), $sformatf("fill_%0d", i));
        end
        add_step(OP_BLOCKED, ENQUEUE_ADDR, 32'h0000_0077, "write_when_full");
        add_step(OP_POP, POP_ADDR, '0, "pop_fill_0");
        add_step(OP_BLOCKED, 2'd0, 32'h0000_0155, "write_bad_addr");   // One credit free here
        add_step(OP_ENQ, ENQUEUE_ADDR, 32'h0000_01AB, "enq_after_pop");
        add_step(OP_PEEK, PEEK_ADDR, '0, "peek_fill_1");
        for (int i = 0; i < DEFAULT_QUEUE_DEPTH; i++) begin
            add_step(OP_POP, POP_ADDR, '0, $sformatf("drain_%0d", i));
        end
        cycle_limit = STEP_CYCLES * step_op.size() + RESET_CYCLES;

        repeat (RESET_CYCLES) @(posedge s_axi_aclk);
        s_axi_aresetn <= 1'b0;
        @(posedge s_axi_aclk);
        check_flag("after_reset", 1'b0, pr_request_pending);

        foreach (step_op[i]) begin
            case (step_op[i])
                OP_ENQ: begin
                    take_bits(23, rnd);                // Noise in the dropped upper bits
                    wdata_now = step_data[i] ^ {rnd[22:0], 9'h000};
                    do_write(step_name[i], step_addr[i], wdata_now, 1'b1);
                    model_q.push_back(wdata_now[PR_REQUEST_W-1:0]);
                end
                OP_BLOCKED: begin
                    do_write(step_name[i], step_addr[i], step_data[i], 1'b0);
                end
                default: begin
                    exp = (model_q.size() != 0) ? model_q[0] : '0;
                    do_read(step_name[i], step_addr[i], exp);
                    if (step_op[i] == OP_POP && model_q.size() != 0) begin
                        void'(model_q.pop_front());
                    end
                end
            endcase
            @(posedge s_axi_aclk);
            check_flag(step_name[i], model_q.size() != 0, pr_request_pending);
        end

        $display("Errors: %0d mismatches, %0d handshake failures",
                 mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: axi_pr_queue.f
pr_queue_pkg.sv
pr_fifo_if.sv
pr_write_decode.sv
pr_request_fifo.sv
pr_read_result.sv
axi_pr_queue.sv
tb_axi_pr_queue.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and looks for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f axi_pr_queue.f --top-module tb_axi_pr_queue -o sim_tb

sim_output=$(./obj_dir/sim_tb)
echo "$sim_output"

if grep -qF "*** TEST PASSED ***" <<< "$sim_output"; then
    exit 0
else
    exit 1
fi
